/* hw/idu_alu_ctrl.sv */
// alu control decoder: operation, operand sources and word truncation per class
`default_nettype none
`timescale 1ns/1ps

module idu_alu_ctrl
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;
(
  input  op_class_e            i_class,
  input  logic [INST_WD-1:0]   i_inst,
  input  logic [FUNCT3_WD-1:0] i_funct3,
  input  logic [FUNCT7_WD-1:0] i_funct7,
  output alu_op_e              o_alu_op,
  output alu_src1_e            o_alu_src1_sel,
  output alu_src2_e            o_alu_src2_sel,
  output logic                 o_alu_word_cut_sel
);

  logic    reg_form;   // rs2 operand, funct7 fully meaningful
  logic    alt_op;
  alu_op_e funct_op;

  assign reg_form = (i_class == CLS_OP) || (i_class == CLS_OP32);
  // shift-imm keeps the arithmetic flag in bit 30 only
  assign alt_op   = reg_form ? (i_funct7 == FUNCT7_ALT) : i_inst[30];

  always_comb begin
    case (i_funct3)
      3'b000:  funct_op = (reg_form && alt_op) ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (i_class)
      CLS_LUI:
        o_alu_op = ALU_COPY_IMM;
      CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_LOAD, CLS_STORE:
        o_alu_op = ALU_ADD;   // address or pc sum
      CLS_OP, CLS_OP32, CLS_OP_IMM, CLS_OP_IMM32:
        o_alu_op = funct_op;
      default:
        o_alu_op = ALU_NOP;
    endcase
  end

  always_comb begin
    case (i_class)
      CLS_JAL, CLS_JALR:
        o_alu_src2_sel = SRC2_FOUR;
      CLS_LUI, CLS_AUIPC, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP_IMM32:
        o_alu_src2_sel = SRC2_IMM;
      CLS_SYS_CSR:
        o_alu_src2_sel = (i_funct3 == F3_CSRRWI) ? SRC2_IMM : SRC2_RS2;
      default:
        o_alu_src2_sel = SRC2_RS2;
    endcase
  end

  assign o_alu_src1_sel = (i_class inside {CLS_AUIPC, CLS_JAL, CLS_JALR}) ? SRC1_PC : SRC1_RS1;
  assign o_alu_word_cut_sel = (i_class == CLS_OP32) || (i_class == CLS_OP_IMM32);

endmodule

`default_nettype wire

/* hw/idu_ctrl_pkg.sv */
// decode control package: encodings of the control fields handed to execute
`default_nettype none

package idu_ctrl_pkg;

  typedef enum logic [3:0] {
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_OP_IMM,
    CLS_OP_IMM32,
    CLS_OP,
    CLS_OP32,
    CLS_SYS_CSR,
    CLS_SYS_PRIV,   // ecall, ebreak, mret
    CLS_ILLEGAL
  } op_class_e;

  typedef enum logic [2:0] {
    IMM_I    = 3'b000,
    IMM_U    = 3'b001,
    IMM_S    = 3'b010,
    IMM_B    = 3'b011,
    IMM_J    = 3'b100,
    IMM_Z    = 3'b101,  // csr uimm
    IMM_NONE = 3'b111
  } imm_fmt_e;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'b00000,
    ALU_SUB      = 5'b00001,
    ALU_SLT      = 5'b00010,
    ALU_SLTU     = 5'b00011,
    ALU_XOR      = 5'b00100,
    ALU_AND      = 5'b00101,
    ALU_OR       = 5'b00110,
    ALU_SLL      = 5'b00111,
    ALU_SRL      = 5'b01000,
    ALU_SRA      = 5'b01001,
    ALU_COPY_IMM = 5'b01111,
    ALU_NOP      = 5'b11111
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } alu_src1_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'b00,
    SRC2_IMM  = 2'b01,
    SRC2_FOUR = 2'b10   // return address pc+4
  } alu_src2_e;

  typedef enum logic [2:0] {
    BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_func_e;

  // stores reuse the signed codes
  typedef enum logic [2:0] {
    MEM_SB, MEM_UB, MEM_SH, MEM_UH, MEM_SW, MEM_UW, MEM_SD, MEM_NONE
  } mem_op_e;

endpackage

`default_nettype wire

/* hw/idu_imm_gen.sv */
// immediate generator: assembles and sign-extends the immediate of the given format
`default_nettype none
`timescale 1ns/1ps

module idu_imm_gen
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;
(
  input  logic [INST_WD-1:0] i_inst,
  input  imm_fmt_e           i_imm_fmt,
  output logic [XLEN-1:0]    o_imm
);

  logic sign;

  assign sign = i_inst[INST_WD-1];

  always_comb begin
    case (i_imm_fmt)
      IMM_I:   o_imm = {{(XLEN-12){sign}}, i_inst[31:20]};
      IMM_U:   o_imm = {{(XLEN-32){sign}}, i_inst[31:12], 12'b0};
      IMM_S:   o_imm = {{(XLEN-12){sign}}, i_inst[31:25], i_inst[11:7]};
      IMM_B:   o_imm = {{(XLEN-12){sign}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      IMM_J:   o_imm = {{(XLEN-20){sign}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      // csrrwi takes the rs1 field as unsigned uimm
      IMM_Z:   o_imm = {{(XLEN-GPR_ADDR_WD){1'b0}}, i_inst[RS1_LSB +: GPR_ADDR_WD]};
      default: o_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/idu_opclass_decode.sv */
// opcode class decoder that maps the major opcode to a class and checks funct legality
`default_nettype none
`timescale 1ns/1ps

module idu_opclass_decode
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;
(
  input  opcode_e              i_opcode,
  input  logic [FUNCT3_WD-1:0] i_funct3,
  input  logic [FUNCT7_WD-1:0] i_funct7,
  input  logic [INST_WD-1:0]   i_inst,
  output op_class_e            o_class,
  output imm_fmt_e             o_imm_fmt,
  output logic                 o_illegal
);

  op_class_e cls;
  logic      legal;
  logic      f7_base;
  logic      f7_alt;
  logic      shamt_ok;   // rv64 shift-imm keeps shamt[5] in bit 25
  logic      sys_word;

  assign f7_base  = (i_funct7 == FUNCT7_BASE);
  assign f7_alt   = (i_funct7 == FUNCT7_ALT);
  assign shamt_ok = (i_funct7[6:1] == FUNCT7_BASE[6:1]) || (i_funct7[6:1] == FUNCT7_ALT[6:1]);
  assign sys_word = (i_inst == INST_ECALL) || (i_inst == INST_EBREAK) || (i_inst == INST_MRET);

  always_comb begin
    case (i_opcode)
      OPC_LUI:      cls = CLS_LUI;
      OPC_AUIPC:    cls = CLS_AUIPC;
      OPC_JAL:      cls = CLS_JAL;
      OPC_JALR:     cls = CLS_JALR;
      OPC_BRANCH:   cls = CLS_BRANCH;
      OPC_LOAD:     cls = CLS_LOAD;
      OPC_STORE:    cls = CLS_STORE;
      OPC_OP_IMM:   cls = CLS_OP_IMM;
      OPC_OP_IMM32: cls = CLS_OP_IMM32;
      OPC_OP:       cls = CLS_OP;
      OPC_OP32:     cls = CLS_OP32;
      OPC_SYSTEM:   cls = (i_funct3 == 3'b000) ? CLS_SYS_PRIV : CLS_SYS_CSR;
      default:      cls = CLS_ILLEGAL;
    endcase
  end

  always_comb begin
    case (cls)
      CLS_LUI, CLS_AUIPC, CLS_JAL: legal = 1'b1;
      CLS_JALR:     legal = (i_funct3 == 3'b000);
      CLS_BRANCH:   legal = (i_funct3[2:1] != 2'b01);
      CLS_LOAD:     legal = (i_funct3 != 3'b111);
      CLS_STORE:    legal = !i_funct3[2];  // sb..sd
      CLS_OP_IMM:   legal = (i_funct3 == 3'b001) ? (i_funct7[6:1] == FUNCT7_BASE[6:1]) :
                            (i_funct3 == 3'b101) ? shamt_ok : 1'b1;
      CLS_OP_IMM32: legal = (i_funct3 == 3'b000) || (i_funct3 == 3'b001 && f7_base) ||
                            (i_funct3 == 3'b101 && (f7_base || f7_alt));
      CLS_OP:       legal = f7_base || (f7_alt && (i_funct3 == 3'b000 || i_funct3 == 3'b101));
      CLS_OP32:     legal = ((f7_base || f7_alt) && (i_funct3 == 3'b000 || i_funct3 == 3'b101)) ||
                            (f7_base && i_funct3 == 3'b001);
      CLS_SYS_CSR:  legal = (i_funct3 == F3_CSRRW) || (i_funct3 == F3_CSRRS) ||
                            (i_funct3 == F3_CSRRWI);
      CLS_SYS_PRIV: legal = sys_word;
      default:      legal = 1'b0;
    endcase
  end

  assign o_illegal = !legal || (i_inst == '0);
  assign o_class   = legal ? cls : CLS_ILLEGAL;

  always_comb begin
    case (o_class)
      CLS_LUI, CLS_AUIPC: o_imm_fmt = IMM_U;
      CLS_JAL:            o_imm_fmt = IMM_J;
      CLS_BRANCH:         o_imm_fmt = IMM_B;
      CLS_STORE:          o_imm_fmt = IMM_S;
      CLS_JALR, CLS_LOAD, CLS_OP_IMM, CLS_OP_IMM32: o_imm_fmt = IMM_I;
      CLS_SYS_CSR:        o_imm_fmt = (i_funct3 == F3_CSRRWI) ? IMM_Z : IMM_I;
      default:            o_imm_fmt = IMM_NONE;
    endcase
  end

  always_comb begin
    a_class_flag: assert ((o_class == CLS_ILLEGAL) == o_illegal)
      else $error("illegal flag and class disagree");
  end

endmodule

`default_nettype wire

/* hw/idu_side_ctrl.sv */
// side control decoder: branch, memory, register write, csr and system flags
`default_nettype none
`timescale 1ns/1ps

module idu_side_ctrl
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;
(
  input  op_class_e              i_class,
  input  logic [FUNCT3_WD-1:0]   i_funct3,
  input  logic [GPR_ADDR_WD-1:0] i_rd,
  input  logic [GPR_ADDR_WD-1:0] i_rs1,
  input  logic [INST_WD-1:0]     i_inst,
  output logic                   o_bren,
  output br_func_e               o_brfunc,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output mem_op_e                o_mem_op,
  output logic                   o_load_sel,
  output logic                   o_gpr_wen,
  output logic                   o_csr_inst_sel,
  output logic                   o_csr_ren,
  output logic                   o_csr_wen,
  output logic [FUNCT3_WD-1:0]   o_csr_op,
  output logic                   o_ecall_sel,
  output logic                   o_ebreak_sel,
  output logic                   o_mret_sel
);

  logic     is_priv;
  br_func_e cond_func;
  mem_op_e  width_op;

  assign is_priv = (i_class == CLS_SYS_PRIV);

  always_comb begin
    case (i_funct3)
      3'b000:  cond_func = BR_BEQ;
      3'b001:  cond_func = BR_BNE;
      3'b100:  cond_func = BR_BLT;
      3'b101:  cond_func = BR_BGE;
      3'b110:  cond_func = BR_BLTU;
      default: cond_func = BR_BGEU;
    endcase
  end

  always_comb begin
    case (i_class)
      CLS_JALR:   o_brfunc = BR_JALR;
      CLS_BRANCH: o_brfunc = cond_func;
      default:    o_brfunc = BR_JAL;  // idle code as well
    endcase
  end

  assign o_bren = (i_class inside {CLS_BRANCH, CLS_JAL, CLS_JALR});

  always_comb begin
    case (i_funct3)
      3'b000:  width_op = MEM_SB;
      3'b001:  width_op = MEM_SH;
      3'b010:  width_op = MEM_SW;
      3'b011:  width_op = MEM_SD;
      3'b100:  width_op = MEM_UB;
      3'b101:  width_op = MEM_UH;
      3'b110:  width_op = MEM_UW;
      default: width_op = MEM_NONE;
    endcase
  end

  assign o_mem_ren  = (i_class == CLS_LOAD);
  assign o_mem_wen  = (i_class == CLS_STORE);
  assign o_mem_op   = (o_mem_ren || o_mem_wen) ? width_op : MEM_NONE;
  assign o_load_sel = o_mem_ren;   // load-use stall hint
  assign o_gpr_wen  = !(i_class inside {CLS_BRANCH, CLS_STORE, CLS_SYS_PRIV, CLS_ILLEGAL});

  assign o_csr_inst_sel = (i_class == CLS_SYS_CSR);
  // csrrw to x0 has no read side effect, csrrs from x0 no write
  assign o_csr_ren = o_csr_inst_sel && !(i_funct3 == F3_CSRRW && i_rd == '0);
  assign o_csr_wen = o_csr_inst_sel && !(i_funct3 == F3_CSRRS && i_rs1 == '0);
  assign o_csr_op  = o_csr_inst_sel ? i_funct3 : '0;

  assign o_ecall_sel  = is_priv && (i_inst == INST_ECALL);
  assign o_ebreak_sel = is_priv && (i_inst == INST_EBREAK);
  assign o_mret_sel   = is_priv && (i_inst == INST_MRET);

  always_comb begin
    a_mem_excl: assert (!(o_mem_ren && o_mem_wen))
      else $error("load and store enables both set");
  end

endmodule

`default_nettype wire

/* hw/idu_top.sv */
// decode stage top: splits the instruction, runs the decoders and latches the result
`default_nettype none
`timescale 1ns/1ps

module idu_top
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic [INST_WD-1:0]     i_inst,
  input  logic                   i_inst_valid,
  output logic                   o_valid,
  output logic [GPR_ADDR_WD-1:0] o_rs1,
  output logic [GPR_ADDR_WD-1:0] o_rs2,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic [CSR_ADDR_WD-1:0] o_csr,
  output logic [XLEN-1:0]        o_imm,
  output logic                   o_bren,
  output br_func_e               o_brfunc,
  output alu_src1_e              o_alu_src1_sel,
  output alu_src2_e              o_alu_src2_sel,
  output alu_op_e                o_alu_op,
  output logic                   o_alu_word_cut_sel,
  output logic                   o_gpr_wen,
  output logic                   o_csr_ren,
  output logic                   o_csr_wen,
  output logic                   o_mem_wen,
  output logic                   o_mem_ren,
  output mem_op_e                o_mem_op,
  output logic                   o_csr_inst_sel,  // rd gets csr data
  output logic                   o_load_sel,
  output logic [FUNCT3_WD-1:0]   o_csr_op,
  output logic                   o_ecall_sel,
  output logic                   o_ebreak_sel,
  output logic                   o_mret_sel,
  output logic                   o_invalid_inst_sel
);

  opcode_e              opcode;
  logic [FUNCT3_WD-1:0] funct3;
  logic [FUNCT7_WD-1:0] funct7;
  logic [GPR_ADDR_WD-1:0] rd;
  logic [GPR_ADDR_WD-1:0] rs1;
  op_class_e            op_class;
  imm_fmt_e             imm_fmt;
  logic                 illegal;
  logic [XLEN-1:0]      imm;
  alu_op_e              alu_op;
  alu_src1_e            src1_sel;
  alu_src2_e            src2_sel;
  logic                 word_cut;
  logic                 bren;
  br_func_e             brfunc;
  logic                 mem_ren;
  logic                 mem_wen;
  mem_op_e              mem_op;
  logic                 load_sel;
  logic                 gpr_wen;
  logic                 csr_inst_sel;
  logic                 csr_ren;
  logic                 csr_wen;
  logic [FUNCT3_WD-1:0] csr_op;
  logic                 ecall;
  logic                 ebreak;
  logic                 mret;

  assign opcode = opcode_e'(i_inst[OPCODE_WD-1:0]);
  assign funct3 = i_inst[FUNCT3_LSB +: FUNCT3_WD];
  assign funct7 = i_inst[FUNCT7_LSB +: FUNCT7_WD];
  assign rd     = i_inst[RD_LSB +: GPR_ADDR_WD];
  assign rs1    = i_inst[RS1_LSB +: GPR_ADDR_WD];

  idu_opclass_decode u_opclass (
    .i_opcode  (opcode),
    .i_funct3  (funct3),
    .i_funct7  (funct7),
    .i_inst    (i_inst),
    .o_class   (op_class),
    .o_imm_fmt (imm_fmt),
    .o_illegal (illegal)
  );

  idu_imm_gen u_imm_gen (
    .i_inst    (i_inst),
    .i_imm_fmt (imm_fmt),
    .o_imm     (imm)
  );

  idu_alu_ctrl u_alu_ctrl (
    .i_class            (op_class),
    .i_inst             (i_inst),
    .i_funct3           (funct3),
    .i_funct7           (funct7),
    .o_alu_op           (alu_op),
    .o_alu_src1_sel     (src1_sel),
    .o_alu_src2_sel     (src2_sel),
    .o_alu_word_cut_sel (word_cut)
  );

  idu_side_ctrl u_side_ctrl (
    .i_class        (op_class),
    .i_funct3       (funct3),
    .i_rd           (rd),
    .i_rs1          (rs1),
    .i_inst         (i_inst),
    .o_bren         (bren),
    .o_brfunc       (brfunc),
    .o_mem_ren      (mem_ren),
    .o_mem_wen      (mem_wen),
    .o_mem_op       (mem_op),
    .o_load_sel     (load_sel),
    .o_gpr_wen      (gpr_wen),
    .o_csr_inst_sel (csr_inst_sel),
    .o_csr_ren      (csr_ren),
    .o_csr_wen      (csr_wen),
    .o_csr_op       (csr_op),
    .o_ecall_sel    (ecall),
    .o_ebreak_sel   (ebreak),
    .o_mret_sel     (mret)
  );

  // decode-to-execute latch, enables qualified by the strobe
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid            <= 1'b0;
      o_gpr_wen          <= 1'b0;
      o_mem_ren          <= 1'b0;
      o_mem_wen          <= 1'b0;
      o_csr_ren          <= 1'b0;
      o_csr_wen          <= 1'b0;
      o_bren             <= 1'b0;
      o_load_sel         <= 1'b0;
      o_ecall_sel        <= 1'b0;
      o_ebreak_sel       <= 1'b0;
      o_mret_sel         <= 1'b0;
      o_invalid_inst_sel <= 1'b0;
    end else begin
      o_valid            <= i_inst_valid;
      o_gpr_wen          <= i_inst_valid & gpr_wen;
      o_mem_ren          <= i_inst_valid & mem_ren;
      o_mem_wen          <= i_inst_valid & mem_wen;
      o_csr_ren          <= i_inst_valid & csr_ren;
      o_csr_wen          <= i_inst_valid & csr_wen;
      o_bren             <= i_inst_valid & bren;
      o_load_sel         <= i_inst_valid & load_sel;
      o_ecall_sel        <= i_inst_valid & ecall;
      o_ebreak_sel       <= i_inst_valid & ebreak;
      o_mret_sel         <= i_inst_valid & mret;
      o_invalid_inst_sel <= i_inst_valid & illegal;
    end
  end

  // fields follow every cycle
  always_ff @(posedge i_clk) begin
    o_rs1              <= rs1;
    o_rs2              <= i_inst[RS2_LSB +: GPR_ADDR_WD];
    o_rd               <= rd;
    o_csr              <= i_inst[CSR_LSB +: CSR_ADDR_WD];
    o_imm              <= imm;
    o_brfunc           <= brfunc;
    o_alu_src1_sel     <= src1_sel;
    o_alu_src2_sel     <= src2_sel;
    o_alu_op           <= alu_op;
    o_alu_word_cut_sel <= word_cut;
    o_mem_op           <= mem_op;
    o_csr_inst_sel     <= csr_inst_sel;
    o_csr_op           <= csr_op;
  end

  a_valid_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_valid)
    else $error("o_valid set in the cycle after reset");

  a_sys_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0({o_ecall_sel, o_ebreak_sel, o_mret_sel}))
    else $error("more than one system flag raised");

endmodule

`default_nettype wire

/* hw/rv_isa_pkg.sv */
// rv64 isa package: instruction field layout, widths, major opcodes and fixed system words
`default_nettype none

package rv_isa_pkg;

  localparam int INST_WD     = 32;
  localparam int XLEN        = 64;  // data and immediate width
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;
  localparam int OPCODE_WD   = 7;
  localparam int FUNCT3_WD   = 3;
  localparam int FUNCT7_WD   = 7;

  // field lsb positions
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int CSR_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  typedef enum logic [OPCODE_WD-1:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP_IMM32 = 7'b0011011,
    OPC_OP       = 7'b0110011,
    OPC_OP32     = 7'b0111011,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  localparam logic [FUNCT7_WD-1:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [FUNCT7_WD-1:0] FUNCT7_ALT  = 7'b0100000;  // sub, sra

  // zicsr subset
  localparam logic [FUNCT3_WD-1:0] F3_CSRRW  = 3'b001;
  localparam logic [FUNCT3_WD-1:0] F3_CSRRS  = 3'b010;
  localparam logic [FUNCT3_WD-1:0] F3_CSRRWI = 3'b101;

  localparam logic [INST_WD-1:0] INST_ECALL  = 32'h0000_0073;
  localparam logic [INST_WD-1:0] INST_EBREAK = 32'h0010_0073;
  localparam logic [INST_WD-1:0] INST_MRET   = 32'h3020_0073;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f rv64_idu.f --top-module idu_tb -o idu_sim || exit 1
./obj_dir/idu_sim | tee /dev/stderr | grep -q "All tests passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* rv64_idu.f */
hw/rv_isa_pkg.sv
hw/idu_ctrl_pkg.sv
hw/idu_opclass_decode.sv
hw/idu_imm_gen.sv
hw/idu_alu_ctrl.sv
hw/idu_side_ctrl.sv
hw/idu_top.sv
+incdir+verification
verification/idu_tb.sv

/* verification/idu_ref_model.svh */
// decode reference model: legality, immediates and the random instruction generator
`ifndef IDU_REF_MODEL_SVH
`define IDU_REF_MODEL_SVH

// class of a word, CLS_ILLEGAL when no legal encoding matches
function automatic op_class_e ref_class(logic [31:0] w);
  logic [2:0] f3;
  logic [6:0] f7;
  logic       ok;
  op_class_e  c;
  f3 = w[14:12];
  f7 = w[31:25];
  c  = CLS_ILLEGAL;
  ok = 1'b0;
  case (w[6:0])
    7'b0110111: begin c = CLS_LUI;    ok = 1'b1; end
    7'b0010111: begin c = CLS_AUIPC;  ok = 1'b1; end
    7'b1101111: begin c = CLS_JAL;    ok = 1'b1; end
    7'b1100111: begin c = CLS_JALR;   ok = (f3 == 3'b000); end
    7'b1100011: begin c = CLS_BRANCH; ok = (f3 != 3'b010) && (f3 != 3'b011); end
    7'b0000011: begin c = CLS_LOAD;   ok = (f3 != 3'b111); end
    7'b0100011: begin c = CLS_STORE;  ok = (f3 <= 3'b011); end
    7'b0010011: begin
      c  = CLS_OP_IMM;
      ok = 1'b1;
      if (f3 == 3'b001) ok = (f7[6:1] == 6'b000000);
      if (f3 == 3'b101) ok = (f7[6:1] == 6'b000000) || (f7[6:1] == 6'b010000);
    end
    7'b0011011: begin
      c  = CLS_OP_IMM32;
      ok = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'h00) ||
           (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
    end
    7'b0110011: begin
      c  = CLS_OP;
      ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
    end
    7'b0111011: begin
      c  = CLS_OP32;
      ok = ((f7 == 7'h00 || f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)) ||
           (f7 == 7'h00 && f3 == 3'b001);
    end
    7'b1110011: begin
      if (f3 == 3'b000) begin
        c  = CLS_SYS_PRIV;
        ok = (w == 32'h0000_0073) || (w == 32'h0010_0073) || (w == 32'h3020_0073);
      end else begin
        c  = CLS_SYS_CSR;
        ok = (f3 == 3'b001) || (f3 == 3'b010) || (f3 == 3'b101);
      end
    end
    default: ok = 1'b0;
  endcase
  return ok ? c : CLS_ILLEGAL;
endfunction

function automatic logic [63:0] ref_imm(logic [31:0] w, op_class_e c);
  logic [63:0] v;
  case (c)
    CLS_LUI, CLS_AUIPC: v = {{32{w[31]}}, w[31:12], 12'b0};
    CLS_JAL:            v = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    CLS_BRANCH:         v = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    CLS_STORE:          v = {{52{w[31]}}, w[31:25], w[11:7]};
    CLS_JALR, CLS_LOAD, CLS_OP_IMM, CLS_OP_IMM32: v = {{52{w[31]}}, w[31:20]};
    CLS_SYS_CSR:
      v = (w[14:12] == 3'b101) ? {59'b0, w[19:15]} : {{52{w[31]}}, w[31:20]};
    default:            v = 64'b0;
  endcase
  return v;
endfunction

// kinds 0..12 legal templates, 13 random, 14 m-extension, 15 zero word
function automatic logic [31:0] gen_inst(int kind, logic [31:0] r0, logic [31:0] r1);
  logic [31:0] w;
  logic [2:0]  f3;
  logic [6:0]  f7;
  w  = r0;
  f3 = r1[2:0];
  f7 = 7'b0;
  case (kind)
    0: w[6:0] = 7'b0110111;
    1: w[6:0] = 7'b0010111;
    2: w[6:0] = 7'b1101111;
    3: begin
      w[14:12] = 3'b000;
      w[6:0]   = 7'b1100111;
    end
    4: begin
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // skip the two holes
      w[14:12] = f3;
      w[6:0]   = 7'b1100011;
    end
    5: begin
      w[14:12] = (f3 == 3'b111) ? 3'b011 : f3;
      w[6:0]   = 7'b0000011;
    end
    6: begin
      w[14:12] = {1'b0, f3[1:0]};
      w[6:0]   = 7'b0100011;
    end
    7: begin
      if (f3 == 3'b001) f7 = {6'b0, r0[25]};
      else if (f3 == 3'b101) f7 = {r1[3] ? 6'b010000 : 6'b000000, r0[25]};
      else f7 = r0[31:25];
      w[31:25] = f7;
      w[14:12] = f3;
      w[6:0]   = 7'b0010011;
    end
    8, 10: begin
      f3 = r1[1] ? 3'b101 : {2'b00, r1[0]};
      if (r1[3] && (f3 == 3'b101 || (kind == 10 && f3 == 3'b000))) f7 = 7'h20;
      w[31:25] = f7;
      w[14:12] = f3;
      w[6:0]   = (kind == 8) ? 7'b0011011 : 7'b0111011;
    end
    9: begin
      if (r1[3] && (f3 == 3'b000 || f3 == 3'b101)) f7 = 7'h20;
      w[31:25] = f7;
      w[14:12] = f3;
      w[6:0]   = 7'b0110011;
    end
    11: begin
      w[14:12] = r1[1] ? 3'b101 : (r1[0] ? 3'b010 : 3'b001);
      if (r1[4]) w[11:7] = 5'b0;   // rd = x0
      if (r1[5]) w[19:15] = 5'b0;  // rs1 = x0
      w[6:0] = 7'b1110011;
    end
    12: begin
      if (r1[1:0] == 2'b00) w = 32'h0000_0073;
      else if (r1[1:0] == 2'b01) w = 32'h0010_0073;
      else w = 32'h3020_0073;
    end
    13: w = r0;
    14: begin
      w[31:25] = 7'b0000001;
      w[6:0]   = r1[0] ? 7'b0110011 : 7'b0111011;
    end
    default: w = 32'b0;
  endcase
  return w;
endfunction

`endif

/* verification/idu_tb.sv */
// decode stage testbench: random instructions checked against a reference decoder
`default_nettype none
`timescale 1ns/1ps

module idu_tb
  import rv_isa_pkg::*;
  import idu_ctrl_pkg::*;
;

  `include "idu_ref_model.svh"

  localparam int RST_CYCLES = 8;
  localparam int N_PER_TEST = 300;
  localparam int WDOG_CYCLES = RST_CYCLES + 4 + 5 * (N_PER_TEST + 1) + 100;

  logic        clk;
  logic        rst;
  logic [31:0] inst;
  logic        inst_valid;

  logic o_valid, o_bren, o_cut, o_gpr_wen, o_csr_ren, o_csr_wen, o_mem_wen, o_mem_ren;
  logic o_csr_sel, o_load, o_ecall, o_ebreak, o_mret, o_invalid;
  logic [4:0]  o_rs1, o_rs2, o_rd;
  logic [11:0] o_csr;
  logic [63:0] o_imm;
  logic [2:0]  o_csr_op;
  br_func_e    o_brfunc;
  alu_src1_e   o_src1;
  alu_src2_e   o_src2;
  alu_op_e     o_alu_op;
  mem_op_e     o_mem_op;

  // expected outputs of the pending instruction
  logic e_valid, e_bren, e_cut, e_gpr_wen, e_csr_ren, e_csr_wen, e_mem_wen, e_mem_ren;
  logic e_csr_sel, e_load, e_ecall, e_ebreak, e_mret, e_invalid;
  logic [63:0] e_imm;
  logic [2:0]  e_csr_op;
  logic [31:0] e_inst;
  br_func_e    e_brfunc;
  alu_src1_e   e_src1;
  alu_src2_e   e_src2;
  alu_op_e     e_alu_op;
  mem_op_e     e_mem_op;

  integer seed;
  int     errors;
  int     checks;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  logic   pending;

  idu_top uut (
    .i_clk(clk), .i_rst(rst), .i_inst(inst), .i_inst_valid(inst_valid),
    .o_valid(o_valid), .o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(o_rd), .o_csr(o_csr),
    .o_imm(o_imm), .o_bren(o_bren), .o_brfunc(o_brfunc), .o_alu_src1_sel(o_src1),
    .o_alu_src2_sel(o_src2), .o_alu_op(o_alu_op), .o_alu_word_cut_sel(o_cut),
    .o_gpr_wen(o_gpr_wen), .o_csr_ren(o_csr_ren), .o_csr_wen(o_csr_wen),
    .o_mem_wen(o_mem_wen), .o_mem_ren(o_mem_ren), .o_mem_op(o_mem_op),
    .o_csr_inst_sel(o_csr_sel), .o_load_sel(o_load), .o_csr_op(o_csr_op),
    .o_ecall_sel(o_ecall), .o_ebreak_sel(o_ebreak), .o_mret_sel(o_mret),
    .o_invalid_inst_sel(o_invalid)
  );

  always #50 clk = ~clk;

  function automatic alu_op_e arith_op(logic [2:0] f3, logic alt, logic reg_form);
    case (f3)
      3'b000:  return (reg_form && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // reference decode of one word into the e_ signals
  task automatic set_expect(input logic [31:0] w, input logic v);
    op_class_e  c;
    logic [2:0] f3;
    c  = ref_class(w);
    f3 = w[14:12];
    e_inst = w;
    e_valid = v;
    e_imm = ref_imm(w, c);
    e_alu_op = ALU_NOP;
    e_src1 = SRC1_RS1;
    e_src2 = SRC2_RS2;
    e_cut = (c == CLS_OP32) || (c == CLS_OP_IMM32);
    e_bren = c inside {CLS_BRANCH, CLS_JAL, CLS_JALR};
    e_brfunc = BR_JAL;
    e_mem_ren = (c == CLS_LOAD);
    e_mem_wen = (c == CLS_STORE);
    e_load = e_mem_ren;
    e_mem_op = MEM_NONE;
    e_gpr_wen = !(c inside {CLS_BRANCH, CLS_STORE, CLS_SYS_PRIV, CLS_ILLEGAL});
    e_csr_sel = (c == CLS_SYS_CSR);
    e_csr_op = e_csr_sel ? f3 : 3'b000;
    e_csr_ren = e_csr_sel && !(f3 == 3'b001 && w[11:7] == 5'd0);
    e_csr_wen = e_csr_sel && !(f3 == 3'b010 && w[19:15] == 5'd0);
    e_ecall = (c == CLS_SYS_PRIV) && (w == 32'h0000_0073);
    e_ebreak = (c == CLS_SYS_PRIV) && (w == 32'h0010_0073);
    e_mret = (c == CLS_SYS_PRIV) && (w == 32'h3020_0073);
    e_invalid = (c == CLS_ILLEGAL);
    case (c)
      CLS_LUI: begin
        e_alu_op = ALU_COPY_IMM;
        e_src2 = SRC2_IMM;
      end
      CLS_AUIPC: begin
        e_alu_op = ALU_ADD;
        e_src1 = SRC1_PC;
        e_src2 = SRC2_IMM;
      end
      CLS_JAL, CLS_JALR: begin
        e_alu_op = ALU_ADD;
        e_src1 = SRC1_PC;
        e_src2 = SRC2_FOUR;
        if (c == CLS_JALR) e_brfunc = BR_JALR;
      end
      CLS_BRANCH: begin
        case (f3)
          3'b000:  e_brfunc = BR_BEQ;
          3'b001:  e_brfunc = BR_BNE;
          3'b100:  e_brfunc = BR_BLT;
          3'b101:  e_brfunc = BR_BGE;
          3'b110:  e_brfunc = BR_BLTU;
          default: e_brfunc = BR_BGEU;
        endcase
      end
      CLS_LOAD, CLS_STORE: begin
        e_alu_op = ALU_ADD;
        e_src2 = SRC2_IMM;
        case (f3)
          3'b000:  e_mem_op = MEM_SB;
          3'b001:  e_mem_op = MEM_SH;
          3'b010:  e_mem_op = MEM_SW;
          3'b011:  e_mem_op = MEM_SD;
          3'b100:  e_mem_op = MEM_UB;
          3'b101:  e_mem_op = MEM_UH;
          default: e_mem_op = MEM_UW;
        endcase
      end
      CLS_OP_IMM, CLS_OP_IMM32: begin
        e_alu_op = arith_op(f3, w[30], 1'b0);
        e_src2 = SRC2_IMM;
      end
      CLS_OP, CLS_OP32: e_alu_op = arith_op(f3, w[31:25] == 7'h20, 1'b1);
      CLS_SYS_CSR: if (f3 == 3'b101) e_src2 = SRC2_IMM;
      default: ;
    endcase
    // strobe low clears every enable
    e_gpr_wen &= v;
    e_mem_ren &= v;
    e_mem_wen &= v;
    e_csr_ren &= v;
    e_csr_wen &= v;
    e_bren &= v;
    e_load &= v;
    e_ecall &= v;
    e_ebreak &= v;
    e_mret &= v;
    e_invalid &= v;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t: %s is %h, expected %h (inst %h)", $time, name, got, exp, e_inst);
    end
  endtask

  task automatic compare_outputs();
    check_val("o_valid", 64'(o_valid), 64'(e_valid));
    check_val("o_rs1", 64'(o_rs1), 64'(e_inst[19:15]));
    check_val("o_rs2", 64'(o_rs2), 64'(e_inst[24:20]));
    check_val("o_rd", 64'(o_rd), 64'(e_inst[11:7]));
    check_val("o_csr", 64'(o_csr), 64'(e_inst[31:20]));
    check_val("o_imm", o_imm, e_imm);
    check_val("o_alu_op", 64'(o_alu_op), 64'(e_alu_op));
    check_val("o_alu_src1_sel", 64'(o_src1), 64'(e_src1));
    check_val("o_alu_src2_sel", 64'(o_src2), 64'(e_src2));
    check_val("o_alu_word_cut_sel", 64'(o_cut), 64'(e_cut));
    check_val("o_bren", 64'(o_bren), 64'(e_bren));
    check_val("o_brfunc", 64'(o_brfunc), 64'(e_brfunc));
    check_val("o_mem_ren", 64'(o_mem_ren), 64'(e_mem_ren));
    check_val("o_mem_wen", 64'(o_mem_wen), 64'(e_mem_wen));
    check_val("o_mem_op", 64'(o_mem_op), 64'(e_mem_op));
    check_val("o_load_sel", 64'(o_load), 64'(e_load));
    check_val("o_gpr_wen", 64'(o_gpr_wen), 64'(e_gpr_wen));
    check_val("o_csr_inst_sel", 64'(o_csr_sel), 64'(e_csr_sel));
    check_val("o_csr_ren", 64'(o_csr_ren), 64'(e_csr_ren));
    check_val("o_csr_wen", 64'(o_csr_wen), 64'(e_csr_wen));
    check_val("o_csr_op", 64'(o_csr_op), 64'(e_csr_op));
    check_val("o_ecall_sel", 64'(o_ecall), 64'(e_ecall));
    check_val("o_ebreak_sel", 64'(o_ebreak), 64'(e_ebreak));
    check_val("o_mret_sel", 64'(o_mret), 64'(e_mret));
    check_val("o_invalid_inst_sel", 64'(o_invalid), 64'(e_invalid));
    if (o_invalid && (o_gpr_wen || o_mem_ren || o_mem_wen || o_csr_ren || o_csr_wen ||
                      o_bren || o_load || o_ecall || o_ebreak || o_mret)) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t: enable raised with invalid instruction %h", $time, e_inst);
    end
  endtask

  // one cycle: check the previous instruction, then drive the next
  task automatic step(input logic [31:0] w, input logic v);
    @(negedge clk);
    if (pending) compare_outputs();
    inst = w;
    inst_valid = v;
    set_expect(w, v);
    pending = 1'b1;
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    if (pending) compare_outputs();
    pending = 1'b0;
    inst_valid = 1'b0;
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("test %-12s done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic run_random(input string name, input int lo, input int hi, input logic rand_v);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    int          kind;
    for (int n = 0; n < N_PER_TEST; n++) begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      kind = lo + (int'(r2[15:0]) % (hi - lo + 1));
      step(gen_inst(kind, r0, r1), rand_v ? (r2[20] | r2[21]) : 1'b1);
    end
    finish_test(name);
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    rst = 1'b0;
    e_inst = 32'b0;
    check_val("o_valid after reset", 64'(o_valid), 64'd0);
    check_val("enables after reset", 64'({o_gpr_wen, o_mem_ren, o_mem_wen, o_csr_ren,
      o_csr_wen, o_bren, o_load, o_ecall, o_ebreak, o_mret, o_invalid}), 64'd0);
    finish_test("reset");
  endtask

  initial begin
    #(WDOG_CYCLES * 100);
    $display("watchdog expired, the tests did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed = 32'hfab5_a9fd;
    clk = 1'b0;
    rst = 1'b1;
    inst = 32'b0;
    inst_valid = 1'b0;
    pending = 1'b0;
    errors = 0;
    checks = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (RST_CYCLES) @(posedge clk);
    check_reset_state();
    run_random("imm_formats", 0, 11, 1'b0);
    run_random("alu_ctrl", 0, 10, 1'b0);
    run_random("side_ctrl", 0, 10, 1'b1);
    run_random("csr_system", 11, 12, 1'b0);
    run_random("invalid", 13, 15, 1'b1);
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
